// File: Makefile
# verilator build and run for the dma channel register block

VERILATOR ?= verilator
TOP       ?= tb_dma_chn_regs
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: ahb_reg_slave.sv
// ahb-lite slave front end of the dma channel register block.
// qualifies the address phase, decodes the channel register and carries
// the index and direction into the data phase. no wait states, so there
// is no hready. read data is the OR of both bank words while reg_rd is up.

`timescale 1ns/1ps
`default_nettype none

`include "dma_chn_settings.svh"

module ahb_reg_slave (
  input  wire                              hclk,
  input  wire                              hrst_n,
  input  wire                              hsel,
  input  wire dma_ahb_pkg::htrans_e        htrans,
  input  wire                              hwrite,
  input  wire logic [`DMA_DATA_W-1:0]      haddr,
  input  wire dma_ahb_pkg::ahb_word_t      cfg_rdata,
  input  wire dma_ahb_pkg::ahb_word_t      int_rdata,
  output dma_chn_pkg::reg_idx_e            reg_sel,
  output logic                             reg_wr,
  output logic                             reg_rd,
  output dma_ahb_pkg::ahb_word_t           hrdata
);

  import dma_ahb_pkg::*;
  import dma_chn_pkg::*;

  localparam logic [`DMA_DEC_W-1:0] chn_base  = `DMA_CHN_BASE;
  localparam logic [`DMA_DEC_W-3:0] last_word = reg_chn_en;

  logic                  xfer_vld;
  logic [`DMA_DEC_W-1:0] reg_off;
  reg_idx_e              dec_idx;

  // busy and idle cycles are no transfer.
  assign xfer_vld = hsel && (htrans == htrans_nonseq || htrans == htrans_seq);

  assign reg_off = haddr[`DMA_DEC_W-1:0] - chn_base; // below base wraps high.

  always_comb begin
    dec_idx = reg_none;
    if (reg_off[1:0] == 2'b00 && reg_off[`DMA_DEC_W-1:2] <= last_word) begin
      dec_idx = reg_idx_e'(reg_off[5:2]);
    end
  end

  // address phase into data phase.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      reg_sel <= reg_none;
      reg_wr  <= 1'b0;
      reg_rd  <= 1'b0;
    end else begin
      reg_sel <= xfer_vld ? dec_idx : reg_none;
      reg_wr  <= xfer_vld && hwrite;
      reg_rd  <= xfer_vld && !hwrite;
    end
  end

  // each bank returns zero for an index it does not own.
  assign hrdata = reg_rd ? (cfg_rdata | int_rdata) : '0;

endmodule

`default_nettype wire

// File: chn_cfg_regs.sv
// channel setup registers of the dma channel register block.
// source and destination address, control a and b, the channel enable and
// the software trigger. setup writes are dropped while the channel runs.
// the transfer engine clears the enable when it is done.

`timescale 1ns/1ps
`default_nettype none

`include "dma_chn_settings.svh"

module chn_cfg_regs (
  input  wire                              hclk,
  input  wire                              hrst_n,
  input  wire dma_chn_pkg::reg_idx_e       reg_sel,
  input  wire                              reg_wr,
  input  wire dma_ahb_pkg::ahb_word_t      hwdata,
  input  wire                              chn_en_clr,
  output dma_ahb_pkg::ahb_word_t           sarn,
  output dma_ahb_pkg::ahb_word_t           darn,
  output logic [`DMA_BLOCK_TL_W-1:0]       block_tl,
  output dma_chn_pkg::addr_inc_e           sinc,
  output dma_chn_pkg::addr_inc_e           dinc,
  output dma_chn_pkg::tr_width_e           src_tr_width,
  output dma_chn_pkg::tr_width_e           dst_tr_width,
  output dma_chn_pkg::trig_mode_e          trig_mode,
  output logic                             int_en,
  output logic                             chn_en,
  output logic                             soft_trig,
  output dma_ahb_pkg::ahb_word_t           cfg_rdata
);

  import dma_chn_pkg::*;

  logic cfg_wr;

  assign cfg_wr = reg_wr && !chn_en; // lock while enabled.

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      sarn <= '0;
      darn <= '0;
    end else if (cfg_wr) begin
      if (reg_sel == reg_sarn) sarn <= hwdata;
      if (reg_sel == reg_darn) darn <= hwdata;
    end
  end

  // control a.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      block_tl     <= '0;
      sinc         <= addr_inc;
      dinc         <= addr_inc;
      src_tr_width <= tr_byte;
      dst_tr_width <= tr_byte;
    end else if (cfg_wr && reg_sel == reg_ctrl_a) begin
      block_tl     <= hwdata[12 +: `DMA_BLOCK_TL_W];
      sinc         <= addr_inc_e'(hwdata[7:6]);
      dinc         <= addr_inc_e'(hwdata[5:4]);
      src_tr_width <= tr_width_e'(hwdata[3:2]);
      dst_tr_width <= tr_width_e'(hwdata[1:0]);
    end
  end

  // control b.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      trig_mode <= trig_single;
      int_en    <= 1'b0;
    end else if (cfg_wr && reg_sel == reg_ctrl_b) begin
      trig_mode <= trig_mode_e'(hwdata[2:1]);
      int_en    <= hwdata[0];
    end
  end

  // a bus write beats the engine clear on the same edge.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      chn_en    <= 1'b0;
      soft_trig <= 1'b0;
    end else begin
      if (reg_wr && reg_sel == reg_chn_en) begin
        chn_en <= hwdata[0];
      end else if (chn_en_clr) begin
        chn_en <= 1'b0;
      end
      soft_trig <= reg_wr && reg_sel == reg_soft_req && hwdata[0]; // one cycle.
    end
  end

  always_comb begin
    case (reg_sel)
      reg_sarn:   cfg_rdata = sarn;
      reg_darn:   cfg_rdata = darn;
      reg_ctrl_a: cfg_rdata = {{(`DMA_DATA_W-12-`DMA_BLOCK_TL_W){1'b0}}, block_tl, 4'h0,
                               sinc, dinc, src_tr_width, dst_tr_width};
      reg_ctrl_b: cfg_rdata = {{(`DMA_DATA_W-3){1'b0}}, trig_mode, int_en};
      reg_chn_en: cfg_rdata = {{(`DMA_DATA_W-1){1'b0}}, chn_en};
      default:    cfg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: chn_int_regs.sv
// interrupt registers of the dma channel register block.
// sticky status per source, set by one-cycle engine events and cleared
// by writing ones to the clear register. the clear write is registered
// first, so a status bit drops one edge after the write data phase.

`timescale 1ns/1ps
`default_nettype none

`include "dma_chn_settings.svh"

module chn_int_regs (
  input  wire                              hclk,
  input  wire                              hrst_n,
  input  wire dma_chn_pkg::reg_idx_e       reg_sel,
  input  wire                              reg_wr,
  input  wire dma_ahb_pkg::ahb_word_t      hwdata,
  input  wire dma_chn_pkg::int_vec_t       int_events,
  input  wire                              int_en,
  output logic                             int_pend,
  output logic                             chn_irq,
  output dma_ahb_pkg::ahb_word_t           int_rdata
);

  import dma_chn_pkg::*;

  int_vec_t int_mask;
  int_vec_t int_status;
  int_vec_t int_clr; // one-cycle clear pulses.

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      int_mask <= '0;
    end else if (reg_wr && reg_sel == reg_int_mask) begin
      int_mask <= hwdata[`DMA_INT_N-1:0];
    end
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      int_clr <= '0;
    end else if (reg_wr && reg_sel == reg_int_clear) begin
      int_clr <= hwdata[`DMA_INT_N-1:0];
    end else begin
      int_clr <= '0;
    end
  end

  // an event on the clear edge keeps its bit set.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      int_status <= '0;
    end else begin
      int_status <= int_events | (int_status & ~int_clr);
    end
  end

  assign chn_irq  = (|(int_status & int_mask)) && int_en;
  assign int_pend = int_status[src_pend];

  always_comb begin
    case (reg_sel)
      reg_int_mask:   int_rdata = {{(`DMA_DATA_W-`DMA_INT_N){1'b0}}, int_mask};
      reg_int_status: int_rdata = {{(`DMA_DATA_W-`DMA_INT_N){1'b0}}, int_status};
      default:        int_rdata = '0; // clear register reads as zero.
    endcase
  end

endmodule

`default_nettype wire

// File: dma_ahb_pkg.sv
// bus side types for the dma channel register block.
// the slave, the top and the testbench import this for the ahb signals.

`default_nettype none

`include "dma_chn_settings.svh"

package dma_ahb_pkg;

  // ahb transfer type, as carried on htrans.
  typedef enum logic [1:0] {
    htrans_idle   = 2'b00,
    htrans_busy   = 2'b01,
    htrans_nonseq = 2'b10,
    htrans_seq    = 2'b11
  } htrans_e;

  typedef logic [`DMA_DATA_W-1:0] ahb_word_t; // one bus data word.

endpackage

`default_nettype wire

// File: dma_chn_pkg.sv
// channel side types for the dma channel register block.
// register index as seen past the address decode, the control field codes
// and the interrupt source vector with its bit positions.

`default_nettype none

`include "dma_chn_settings.svh"

package dma_chn_pkg;

  // word offset from the channel base.
  typedef enum logic [3:0] {
    reg_sarn       = 4'h0,
    reg_darn       = 4'h1,
    reg_ctrl_a     = 4'h2,
    reg_ctrl_b     = 4'h3,
    reg_int_mask   = 4'h4,
    reg_int_status = 4'h5,
    reg_int_clear  = 4'h6,
    reg_soft_req   = 4'h7,
    reg_chn_en     = 4'h8,
    reg_none       = 4'hf
  } reg_idx_e;

  typedef enum logic [1:0] {addr_inc = 2'b00, addr_dec = 2'b01, addr_fixed = 2'b10} addr_inc_e;

  typedef enum logic [1:0] {tr_byte = 2'b00, tr_half = 2'b01, tr_word = 2'b10} tr_width_e;

  // single transfer, whole block, or rerun until disabled.
  typedef enum logic [1:0] {trig_single = 2'b00, trig_block = 2'b01, trig_cont = 2'b10} trig_mode_e;

  typedef logic [`DMA_INT_N-1:0] int_vec_t;

  // bit positions inside int_vec_t.
  typedef enum int unsigned {
    src_err     = 0,
    src_tfr     = 1,
    src_half    = 2,
    src_trg_cmp = 3,
    src_pend    = 4
  } int_src_e;

endpackage

`default_nettype wire

// File: dma_chn_regs.sv
// register block of one dma channel.
// an ahb-lite slave with no wait states in front of the setup bank and
// the interrupt bank. the transfer engine reads the setup fields and
// returns its events and the enable clear.

`timescale 1ns/1ps
`default_nettype none

`include "dma_chn_settings.svh"

module dma_chn_regs (
  input  wire                              hclk,
  input  wire                              hrst_n,
  input  wire                              hsel,
  input  wire dma_ahb_pkg::htrans_e        htrans,
  input  wire                              hwrite,
  input  wire logic [`DMA_DATA_W-1:0]      haddr,
  input  wire dma_ahb_pkg::ahb_word_t      hwdata,
  output dma_ahb_pkg::ahb_word_t           hrdata,
  input  wire dma_chn_pkg::int_vec_t       int_events,
  input  wire                              chn_en_clr,
  output dma_ahb_pkg::ahb_word_t           sarn,
  output dma_ahb_pkg::ahb_word_t           darn,
  output logic [`DMA_BLOCK_TL_W-1:0]       block_tl,
  output dma_chn_pkg::addr_inc_e           sinc,
  output dma_chn_pkg::addr_inc_e           dinc,
  output dma_chn_pkg::tr_width_e           src_tr_width,
  output dma_chn_pkg::tr_width_e           dst_tr_width,
  output dma_chn_pkg::trig_mode_e          trig_mode,
  output logic                             int_en,
  output logic                             chn_en,
  output logic                             soft_trig,
  output logic                             chn_irq,
  output logic                             int_pend
);

  import dma_ahb_pkg::*;
  import dma_chn_pkg::*;

  reg_idx_e  reg_sel;
  logic      reg_wr;
  logic      reg_rd;
  ahb_word_t cfg_rdata;
  ahb_word_t int_rdata;

  ahb_reg_slave u_slave (
    .hclk      (hclk),
    .hrst_n    (hrst_n),
    .hsel      (hsel),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .haddr     (haddr),
    .cfg_rdata (cfg_rdata),
    .int_rdata (int_rdata),
    .reg_sel   (reg_sel),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .hrdata    (hrdata)
  );

  chn_cfg_regs u_cfg (
    .hclk         (hclk),
    .hrst_n       (hrst_n),
    .reg_sel      (reg_sel),
    .reg_wr       (reg_wr),
    .hwdata       (hwdata),
    .chn_en_clr   (chn_en_clr),
    .sarn         (sarn),
    .darn         (darn),
    .block_tl     (block_tl),
    .sinc         (sinc),
    .dinc         (dinc),
    .src_tr_width (src_tr_width),
    .dst_tr_width (dst_tr_width),
    .trig_mode    (trig_mode),
    .int_en       (int_en),
    .chn_en       (chn_en),
    .soft_trig    (soft_trig),
    .cfg_rdata    (cfg_rdata)
  );

  chn_int_regs u_int (
    .hclk       (hclk),
    .hrst_n     (hrst_n),
    .reg_sel    (reg_sel),
    .reg_wr     (reg_wr),
    .hwdata     (hwdata),
    .int_events (int_events),
    .int_en     (int_en), // enable lives in control b.
    .int_pend   (int_pend),
    .chn_irq    (chn_irq),
    .int_rdata  (int_rdata)
  );

endmodule

`default_nettype wire

// File: dma_chn_settings.svh
// sizing for the dma channel register block.
// include it wherever the bus, the address decode or a field width is needed.
// types built on these values live in the two packages.

`ifndef DMA_CHN_SETTINGS_SVH
`define DMA_CHN_SETTINGS_SVH

// ahb data and address width.
`define DMA_DATA_W 32

// low address bits looked at by the register decode.
`define DMA_DEC_W 10

// first channel register inside the decode window.
`define DMA_CHN_BASE 'h210

`define DMA_BLOCK_TL_W 12 // block transfer length field.

`define DMA_INT_N 5 // interrupt sources per channel.

`endif

// File: sim.f
+incdir+.
dma_ahb_pkg.sv
dma_chn_pkg.sv
ahb_reg_slave.sv
chn_cfg_regs.sv
chn_int_regs.sv
dma_chn_regs.sv
tb_clk_gen.sv
tb_dma_chn_regs.sv

// File: tb_clk_gen.sv
// clock and reset for the dma channel register testbench.
// 8 ns clock, reset held low for the first four cycles.

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic hclk,
  output logic hrst_n
);

  initial begin
    hclk = 1'b0;
    forever #4 hclk = ~hclk;
  end

  initial begin
    hrst_n = 1'b0;
    repeat (4) @(posedge hclk);
    @(negedge hclk);
    hrst_n = 1'b1; // release away from the rising edge.
  end

endmodule

`default_nettype wire

// File: tb_dma_chn_regs.sv
// testbench for the dma channel register block.
// drives ahb transfers and engine events on the falling clock edge, keeps a
// cycle model of the registers and compares bus reads and the channel
// outputs with it. random data comes from one fixed seed.

`timescale 1ns/1ps
`default_nettype none

`include "dma_chn_settings.svh"

module tb_dma_chn_regs;

  import dma_ahb_pkg::*;
  import dma_chn_pkg::*;

  localparam int n_rand     = 64;
  localparam int timeout_ns = (n_rand * 10 + 200) * 8 * 2;
  localparam int pad        = `DMA_DATA_W - `DMA_INT_N;

  logic                       hclk;
  logic                       hrst_n;
  logic                       hsel;
  htrans_e                    htrans;
  logic                       hwrite;
  ahb_word_t                  haddr;
  ahb_word_t                  hwdata;
  ahb_word_t                  hrdata;
  int_vec_t                   int_events;
  logic                       chn_en_clr;
  ahb_word_t                  sarn;
  ahb_word_t                  darn;
  logic [`DMA_BLOCK_TL_W-1:0] block_tl;
  addr_inc_e                  sinc;
  addr_inc_e                  dinc;
  tr_width_e                  src_tr_width;
  tr_width_e                  dst_tr_width;
  trig_mode_e                 trig_mode;
  logic                       int_en;
  logic                       chn_en;
  logic                       soft_trig;
  logic                       chn_irq;
  logic                       int_pend;

  // reference model state.
  ahb_word_t m_sarn;
  ahb_word_t m_darn;
  ahb_word_t m_ctrl_a;
  ahb_word_t m_ctrl_b;
  int_vec_t  m_mask;
  int_vec_t  m_status;
  int_vec_t  m_clr;
  logic      m_chn_en;
  logic      m_soft;
  logic      m_ph_wr; // write in data phase.
  ahb_word_t m_ph_addr;
  int        ph_idx;

  integer seed   = 32'h5ff8;
  int     errors = 0;
  int     checks = 0;
  logic   ev_on  = 1'b0;

  tb_clk_gen u_clk (.*);

  dma_chn_regs DUT (.*);

  function automatic ahb_word_t rnd();
    return $random(seed);
  endfunction

  // word index past the channel base, -1 when nothing is mapped there.
  function automatic int reg_index(input ahb_word_t addr);
    logic [`DMA_DEC_W-1:0] low;
    low = addr[`DMA_DEC_W-1:0];
    if (low < `DMA_CHN_BASE || low > `DMA_CHN_BASE + 'h20 || low[1:0] != 2'b00) return -1;
    return int'((low - `DMA_CHN_BASE) >> 2);
  endfunction

  function automatic ahb_word_t reg_addr(input int idx);
    ahb_word_t a;
    ahb_word_t off;
    a = rnd(); // upper bits are not decoded.
    off = `DMA_CHN_BASE + 4 * idx;
    a[`DMA_DEC_W-1:0] = off[`DMA_DEC_W-1:0];
    return a;
  endfunction

  function automatic ahb_word_t exp_read(input int idx);
    case (idx)
      0: return m_sarn;
      1: return m_darn;
      2: return m_ctrl_a;
      3: return m_ctrl_b;
      4: return {{pad{1'b0}}, m_mask};
      5: return {{pad{1'b0}}, m_status};
      8: return {{(`DMA_DATA_W-1){1'b0}}, m_chn_en};
      default: return '0;
    endcase
  endfunction

  task automatic check_val(input string what, input ahb_word_t got, input ahb_word_t want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  assign ph_idx = m_ph_wr ? reg_index(m_ph_addr) : -1;

  always @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      m_sarn    <= '0;
      m_darn    <= '0;
      m_ctrl_a  <= '0;
      m_ctrl_b  <= '0;
      m_mask    <= '0;
      m_status  <= '0;
      m_clr     <= '0;
      m_chn_en  <= 1'b0;
      m_soft    <= 1'b0;
      m_ph_wr   <= 1'b0;
      m_ph_addr <= '0;
    end else begin
      m_ph_wr   <= hsel && hwrite && (htrans == htrans_nonseq || htrans == htrans_seq);
      m_ph_addr <= haddr;
      m_status  <= int_events | (m_status & ~m_clr); // set beats clear.
      m_clr     <= (ph_idx == 6) ? hwdata[`DMA_INT_N-1:0] : '0;
      m_soft    <= (ph_idx == 7) && hwdata[0];
      if (ph_idx == 4) m_mask <= hwdata[`DMA_INT_N-1:0];
      if (ph_idx == 8) m_chn_en <= hwdata[0];
      else if (chn_en_clr) m_chn_en <= 1'b0;
      if (!m_chn_en) begin
        if (ph_idx == 0) m_sarn <= hwdata;
        if (ph_idx == 1) m_darn <= hwdata;
        if (ph_idx == 2) m_ctrl_a <= hwdata & 32'h00ff_f0ff;
        if (ph_idx == 3) m_ctrl_b <= hwdata & 32'h0000_0007;
      end
    end
  end

  always @(negedge hclk) begin
    if (hrst_n) begin
      check_val("chn_en", 32'(chn_en), 32'(m_chn_en));
      check_val("soft_trig", 32'(soft_trig), 32'(m_soft));
      check_val("chn_irq", 32'(chn_irq), 32'(|(m_status & m_mask) && m_ctrl_b[0]));
      check_val("int_pend", 32'(int_pend), 32'(m_status[4]));
    end
  end

  // sparse engine events.
  initial begin
    ahb_word_t ev;
    int_events = '0;
    forever begin
      @(negedge hclk);
      ev = rnd();
      int_events = ev_on ? (ev[4:0] & ev[9:5] & ev[14:10]) : '0;
    end
  end

  // one ahb transfer, entered and left on a falling edge.
  task automatic bus_cycle(input logic sel, input htrans_e trans, input logic wr,
                           input ahb_word_t addr, input ahb_word_t data,
                           output ahb_word_t rdata);
    ahb_word_t want;
    hsel   = sel;
    htrans = trans;
    hwrite = wr;
    haddr  = addr;
    @(posedge hclk);
    @(negedge hclk);
    hsel   = 1'b0;
    htrans = htrans_idle;
    hwdata = data;
    want   = '0;
    if (sel && !wr && (trans == htrans_nonseq || trans == htrans_seq)) begin
      want = exp_read(reg_index(addr));
    end
    rdata = hrdata;
    check_val("hrdata", rdata, want);
    @(posedge hclk);
    @(negedge hclk);
  endtask

  task automatic write_reg(input int idx, input ahb_word_t data);
    ahb_word_t unused;
    bus_cycle(1'b1, htrans_nonseq, 1'b1, reg_addr(idx), data, unused);
  endtask

  task automatic read_reg(input int idx, output ahb_word_t rdata);
    bus_cycle(1'b1, htrans_seq, 1'b0, reg_addr(idx), '0, rdata);
  endtask

  task automatic check_cfg();
    check_val("sarn", sarn, m_sarn);
    check_val("darn", darn, m_darn);
    check_val("block_tl", 32'(block_tl), 32'(m_ctrl_a[23:12]));
    check_val("sinc", 32'(sinc), 32'(m_ctrl_a[7:6]));
    check_val("dinc", 32'(dinc), 32'(m_ctrl_a[5:4]));
    check_val("src_tr_width", 32'(src_tr_width), 32'(m_ctrl_a[3:2]));
    check_val("dst_tr_width", 32'(dst_tr_width), 32'(m_ctrl_a[1:0]));
    check_val("trig_mode", 32'(trig_mode), 32'(m_ctrl_b[2:1]));
    check_val("int_en", 32'(int_en), 32'(m_ctrl_b[0]));
  endtask

  initial begin
    #(timeout_ns);
    $display("timeout: the tests did not finish within %0d ns", timeout_ns);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    ahb_word_t rdata;
    ahb_word_t held;
    ahb_word_t addr;
    ahb_word_t snap [9];
    int        idx;
    int        pulses;
    int        i;
    hsel       = 1'b0;
    htrans     = htrans_idle;
    hwrite     = 1'b0;
    haddr      = '0;
    hwdata     = '0;
    chn_en_clr = 1'b0;
    wait (hrst_n);
    @(negedge hclk);

    repeat (n_rand) begin
      idx = int'(rnd() % 4);
      write_reg(idx, rnd());
      check_cfg();
      read_reg(idx, rdata);
    end

    // setup is locked while the channel runs.
    write_reg(8, 32'h1);
    held = sarn;
    repeat (n_rand / 2) begin
      write_reg(int'(rnd() % 4), rnd());
      check_cfg();
    end
    check_val("sarn while locked", sarn, held);
    chn_en_clr = 1'b1;
    @(negedge hclk);
    chn_en_clr = 1'b0;
    held = rnd();
    write_reg(0, held);
    check_val("sarn after unlock", sarn, held);
    chn_en_clr = 1'b1; // bus write wins.
    write_reg(8, 32'h1);
    chn_en_clr = 1'b0;
    check_val("chn_en after write over clear", 32'(chn_en), 32'h1);
    write_reg(8, 32'h0);

    for (i = 0; i < 8; i++) begin
      rdata = rnd();
      rdata[0] = i[0];
      write_reg(7, rdata);
      pulses = int'(soft_trig);
      repeat (3) begin
        @(negedge hclk);
        pulses += int'(soft_trig);
      end
      check_val("soft_trig pulse count", 32'(pulses), 32'(rdata[0]));
    end

    ev_on = 1'b1;
    repeat (n_rand * 2) begin
      case (rnd() % 5)
        0: write_reg(4, rnd());
        1: write_reg(6, rnd());
        2: write_reg(3, rnd());
        3: read_reg(4, rdata);
        default: read_reg(5, rdata);
      endcase
    end
    ev_on = 1'b0;
    repeat (2) @(negedge hclk);

    // stray transfers must leave every register alone.
    for (i = 0; i < 9; i++) snap[i] = exp_read(i);
    repeat (n_rand / 2) begin
      held = rnd();
      addr = reg_addr(int'(held[7:4] % 9));
      case (held[1:0])
        2'd0: bus_cycle(1'b0, htrans_nonseq, held[8], addr, rnd(), rdata);
        2'd1: bus_cycle(1'b1, htrans_idle, held[8], addr, rnd(), rdata);
        2'd2: bus_cycle(1'b1, htrans_busy, held[8], addr, rnd(), rdata);
        default: begin
          addr[`DMA_DEC_W-1:0] = held[31:22];
          if (reg_index(addr) >= 0) addr[1:0] = 2'b01;
          bus_cycle(1'b1, htrans_nonseq, held[8], addr, rnd(), rdata);
        end
      endcase
      check_val("stray hrdata", rdata, '0);
    end
    for (i = 0; i < 9; i++) begin
      read_reg(i, rdata);
      check_val("register after stray transfers", rdata, snap[i]);
    end
    check_cfg();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
